// File: fifo_controller.sv
// Strobes must already be qualified by full and empty since the pointers advance on them blindly
`timescale 1ns/1ps

module fifo_controller (
  input  logic              clock,
  input  logic              reset,
  input  logic              write_enable,
  input  logic              read_enable,
  output logic              full,
  output logic              empty,
  input  fifo_pkg::data_t   write_data,
  output fifo_pkg::data_t   read_data,
  fifo_memory_if.controller mem
);
  import fifo_pkg::*;

  // Pointers with wrap bit
  ptr_t write_pointer;
  ptr_t read_pointer;

  // Low pointer bits used as RAM addresses
  addr_t write_address;
  addr_t read_address;

  // High when the pointers are on different laps
  logic wrap_differs;

  // Write pointer moves on each accepted write
  always_ff @(posedge clock) begin
    if (reset) begin
      write_pointer <= '0;
    end else if (write_enable) begin
      write_pointer <= write_pointer + ptr_t'(1);
    end
  end

  // Read pointer moves on each accepted read
  // New head appears on read_data right after this edge
  always_ff @(posedge clock) begin
    if (reset) begin
      read_pointer <= '0;
    end else if (read_enable) begin
      read_pointer <= read_pointer + ptr_t'(1);
    end
  end

  // Drop the wrap bit for addressing
  assign write_address = addr_t'(write_pointer);
  assign read_address  = addr_t'(read_pointer);

  assign wrap_differs = write_pointer[$bits(ptr_t)-1] ^ read_pointer[$bits(ptr_t)-1];

  // Same slot and same lap
  assign empty = (write_pointer == read_pointer);

  // Same slot but writer one lap ahead
  assign full = wrap_differs && (write_address == read_address);

  // RAM write side
  assign mem.write_enable  = write_enable;
  assign mem.write_address = write_address;
  assign mem.write_data    = write_data;

  // RAM read side
  // Level held while a head word exists
  assign mem.read_enable  = ~empty;
  assign mem.read_address = read_address;

  // Head word straight from the RAM
  assign read_data = mem.read_data;

endmodule

// File: fifo_memory_if.sv
// Carries one write port and one read port of the RAM and assumes a combinational read path
`timescale 1ns/1ps

interface fifo_memory_if;
  import fifo_pkg::*;

  // Write port
  logic  write_enable;
  addr_t write_address;
  data_t write_data;

  // Read port
  // read_enable marks a valid head word and is not used for the read itself
  logic  read_enable;
  addr_t read_address;
  data_t read_data;

  // Pointer side drives addresses and write data
  modport controller (
    output write_enable,
    output write_address,
    output write_data,
    output read_enable,
    output read_address,
    input  read_data
  );

  // Storage side returns the addressed word
  modport memory (
    input  write_enable,
    input  write_address,
    input  write_data,
    input  read_enable,
    input  read_address,
    output read_data
  );

endinterface

// File: fifo_occupancy.sv
// Thresholds are fixed by the header and the strobes must be the accepted transfers only
`timescale 1ns/1ps
`include "fifo_params.svh"

module fifo_occupancy (
  input  logic             clock,
  input  logic             reset,
  input  logic             write_enable,
  input  logic             read_enable,
  output fifo_pkg::level_t level,
  output logic             almost_full,
  output logic             almost_empty
);
  import fifo_pkg::*;

  // Count after this edge
  level_t level_next;

  // Up on write alone, down on read alone
  always_comb begin
    case ({write_enable, read_enable})
      2'b10:   level_next = level + level_t'(1);
      2'b01:   level_next = level - level_t'(1);
      default: level_next = level;
    endcase
  end

  // Flags taken from the next count
  // so they land on the same edge as level
  always_ff @(posedge clock) begin
    if (reset) begin
      level        <= '0;
      almost_full  <= 1'b0;
      almost_empty <= 1'b1;
    end else begin
      level        <= level_next;
      almost_full  <= (level_next >= level_t'(`FIFO_ALMOST_FULL));
      almost_empty <= (level_next <= level_t'(`FIFO_ALMOST_EMPTY));
    end
  end

endmodule

// File: fifo_params.svh
// FIFO_DEPTH must be a power of two and at least 4 and the almost thresholds are counts in words
`ifndef FIFO_PARAMS_SVH
`define FIFO_PARAMS_SVH

// Bits per stored word
`define FIFO_WIDTH 8

// Words of storage
// Power of two only, since the pointers wrap by overflow
`define FIFO_DEPTH 8

// Address bits follow the depth
`define FIFO_ADDR_BITS $clog2(`FIFO_DEPTH)

// almost_full is high at or above this level
`define FIFO_ALMOST_FULL 6

// almost_empty is high at or below this level
`define FIFO_ALMOST_EMPTY 1

`endif

// File: fifo_pkg.sv
// Types are sized from the macros in fifo_params.svh and change only by editing that header
`include "fifo_params.svh"

package fifo_pkg;

  // One stored word
  typedef logic [`FIFO_WIDTH-1:0] data_t;

  // RAM address covering every slot once
  typedef logic [`FIFO_ADDR_BITS-1:0] addr_t;

  // Pointer with one extra wrap bit on top
  // Equal pointers mean empty
  // Only the wrap bit differing means full
  typedef logic [`FIFO_ADDR_BITS:0] ptr_t;

  // Stored-word count
  // Needs the extra bit to hold the full depth itself
  typedef logic [`FIFO_ADDR_BITS:0] level_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the pass line

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_valid_ready_fifo

rm -f "$LOG"

verilator --binary --timing -f sources.f --top-module "$TOP" -Mdir obj_dir \
  && ./obj_dir/V"$TOP" > "$LOG" 2>&1 \
  || echo "run_sim: build or run returned an error"

[ -f "$LOG" ] && cat "$LOG"

grep -qx "Simulation PASSED" "$LOG" \
  && { echo "run_sim: pass"; exit 0; } \
  || { echo "run_sim: fail"; exit 1; }

// File: simple_dual_port_ram.sv
// Storage is not reset and reads are combinational so read_data changes as soon as the address does
`timescale 1ns/1ps

module simple_dual_port_ram (
  input  logic          clock,
  fifo_memory_if.memory mem
);
  import fifo_pkg::*;

  // One slot per address value
  localparam int unsigned SLOTS = 2 ** $bits(addr_t);

  // Word array
  // Contents undefined until written
  data_t storage [SLOTS];

  // Clocked write port
  always_ff @(posedge clock) begin
    if (mem.write_enable) begin
      storage[mem.write_address] <= mem.write_data;
    end
  end

  // Unregistered read port
  // Same-cycle read of a slot being written returns the old word,
  // which never happens here since the head slot is never the write slot
  // unless the queue is empty
  always_comb begin
    mem.read_data = storage[mem.read_address];
  end

endmodule

// File: sources.f
+incdir+.
fifo_pkg.sv
fifo_memory_if.sv
simple_dual_port_ram.sv
fifo_controller.sv
fifo_occupancy.sv
valid_ready_fifo.sv
tb_valid_ready_fifo.sv

// File: tb_valid_ready_fifo.sv
// Assumes FIFO_DEPTH 8 and thresholds 6 and 1 for the table levels; the random phase follows any header
`timescale 1ns/1ps
`include "fifo_params.svh"

module tb_valid_ready_fifo;
  import fifo_pkg::*;

  localparam int CLOCK_PERIOD    = 40;
  localparam int TABLE_ROWS      = 31;
  localparam int RANDOM_CYCLES   = 200;
  localparam int WATCHDOG_CYCLES = TABLE_ROWS + RANDOM_CYCLES + 20;
  localparam int RANDOM_SEED     = 32'ha6a157f6;

  // Each row packs write_valid, write_data, read_ready and the level after the edge
  localparam logic [19:0] STIM_TABLE [TABLE_ROWS] = '{
    // Fall-through order, then a refused read on empty
    20'h1_11_0_1, 20'h1_22_0_2, 20'h1_33_0_3,
    20'h0_00_1_2, 20'h0_00_1_1, 20'h0_00_1_0, 20'h0_00_1_0,
    // Fill to the top, ninth write refused
    20'h1_a0_0_1, 20'h1_a1_0_2, 20'h1_a2_0_3, 20'h1_a3_0_4,
    20'h1_a4_0_5, 20'h1_a5_0_6, 20'h1_a6_0_7, 20'h1_a7_0_8,
    20'h1_ee_0_8,
    // Back-pressure holds the head
    20'h0_00_0_8, 20'h0_00_0_8,
    // Full with both strobes, only the read goes
    20'h1_ef_1_7,
    20'h0_00_1_6, 20'h0_00_1_5, 20'h0_00_1_4,
    // Read and write together at level 4
    20'h1_b0_1_4, 20'h1_b1_1_4, 20'h1_b2_1_4,
    // Drain to empty
    20'h0_00_1_3, 20'h0_00_1_2, 20'h0_00_1_1, 20'h0_00_1_0,
    // Empty with both strobes, only the write goes
    20'h1_c5_1_1, 20'h0_00_1_0
  };

  logic   clock;
  logic   reset;
  logic   full;
  logic   empty;
  data_t  write_data;
  logic   write_valid;
  logic   write_ready;
  data_t  read_data;
  logic   read_valid;
  logic   read_ready;
  level_t level;
  logic   almost_full;
  logic   almost_empty;

  // Reference queue, oldest word at index 0
  data_t model_q [$];

  int error_count = 0;
  int check_count = 0;

  valid_ready_fifo dut (
    .clock        (clock),
    .reset        (reset),
    .full         (full),
    .empty        (empty),
    .write_data   (write_data),
    .write_valid  (write_valid),
    .write_ready  (write_ready),
    .read_data    (read_data),
    .read_valid   (read_valid),
    .read_ready   (read_ready),
    .level        (level),
    .almost_full  (almost_full),
    .almost_empty (almost_empty)
  );

  always #(CLOCK_PERIOD / 2) clock = ~clock;

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("FAIL %s: got 0x%0h expected 0x%0h at %0t", name, actual, expected, $time);
    end
  endtask

  // Every output against the model count and head
  task automatic check_state();
    int count;
    count = model_q.size();
    check_value("empty", 32'(empty), 32'(count == 0));
    check_value("full", 32'(full), 32'(count == `FIFO_DEPTH));
    check_value("read_valid", 32'(read_valid), 32'(count != 0));
    check_value("write_ready", 32'(write_ready), 32'(count != `FIFO_DEPTH));
    check_value("level", 32'(level), 32'(count));
    check_value("almost_full", 32'(almost_full), 32'(count >= `FIFO_ALMOST_FULL));
    check_value("almost_empty", 32'(almost_empty), 32'(count <= `FIFO_ALMOST_EMPTY));
    if (count != 0) begin
      check_value("read_data", 32'(read_data), 32'(model_q[0]));
    end
  endtask

  // Called 2 ns after an edge, returns 2 ns after the next one
  task automatic run_cycle(input logic wv, input data_t wd, input logic rr);
    logic  push;
    logic  pop;
    check_state();
    write_valid = wv;
    write_data  = wd;
    read_ready  = rr;
    // Acceptance decided on the state before the edge
    pop  = rr && (model_q.size() != 0);
    push = wv && (model_q.size() != `FIFO_DEPTH);
    if (pop) begin
      void'(model_q.pop_front());
    end
    if (push) begin
      model_q.push_back(wd);
    end
    @(posedge clock);
    #2;
  endtask

  initial begin
    logic [19:0] row;
    logic [31:0] rand_word;
    logic        wv;
    logic        rr;
    clock       = 1'b0;
    reset       = 1'b1;
    write_data  = '0;
    write_valid = 1'b0;
    read_ready  = 1'b0;
    repeat (2) @(posedge clock);
    #2;
    reset = 1'b0;
    // Reset values before any transfer
    check_state();

    for (int i = 0; i < TABLE_ROWS; i++) begin
      row = STIM_TABLE[i];
      run_cycle(row[16], row[15:8], row[4]);
      check_value("level (table)", 32'(level), 32'(row[3:0]));
    end

    // Seed once, then mostly writes followed by mostly reads
    rand_word = $urandom(RANDOM_SEED);
    for (int i = 0; i < RANDOM_CYCLES; i++) begin
      rand_word = $urandom();
      if (i < RANDOM_CYCLES / 2) begin
        wv = (rand_word[1:0] != 2'b00);
        rr = (rand_word[3:2] == 2'b00);
      end else begin
        wv = (rand_word[1:0] == 2'b00);
        rr = (rand_word[3:2] != 2'b00);
      end
      run_cycle(wv, rand_word[15:8], rr);
    end

    write_valid = 1'b0;
    read_ready  = 1'b0;
    check_state();

    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Bounds the run at the table, the random phase and some margin
  initial begin
    #(WATCHDOG_CYCLES * CLOCK_PERIOD);
    $display("Timeout: the test sequence did not finish in %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: valid_ready_fifo.sv
// First-word fall-through queue where read_data is only meaningful while read_valid is high
`timescale 1ns/1ps

module valid_ready_fifo (
  input  logic             clock,
  input  logic             reset,
  output logic             full,
  output logic             empty,
  // Write side
  input  fifo_pkg::data_t  write_data,
  input  logic             write_valid,
  output logic             write_ready,
  // Read side
  output fifo_pkg::data_t  read_data,
  output logic             read_valid,
  input  logic             read_ready,
  // Occupancy
  output fifo_pkg::level_t level,
  output logic             almost_full,
  output logic             almost_empty
);

  // Accepted transfers this cycle
  logic write_enable;
  logic read_enable;

  // Ready and valid straight from the queue state
  assign write_ready = ~full;
  assign read_valid  = ~empty;

  // Handshake strobes formed once and shared
  assign write_enable = write_valid & write_ready;
  assign read_enable  = read_valid & read_ready;

  // Bus between pointer logic and storage
  fifo_memory_if memory_bus ();

  // Pointers and status
  fifo_controller controller (
    .clock        (clock),
    .reset        (reset),
    .write_enable (write_enable),
    .read_enable  (read_enable),
    .full         (full),
    .empty        (empty),
    .write_data   (write_data),
    .read_data    (read_data),
    .mem          (memory_bus.controller)
  );

  // Storage with combinational read
  simple_dual_port_ram memory (
    .clock (clock),
    .mem   (memory_bus.memory)
  );

  // Word count and almost flags
  fifo_occupancy occupancy (
    .clock        (clock),
    .reset        (reset),
    .write_enable (write_enable),
    .read_enable  (read_enable),
    .level        (level),
    .almost_full  (almost_full),
    .almost_empty (almost_empty)
  );

endmodule
